// File: Bender.yml
package:
  name: psram_subsys

sources:
  - files:
      - src/psram_pkg.sv
      - src/count_reg.sv
      - src/psram_model.sv
      - src/psram_ctrl.sv
      - src/psram_subsys.sv
  - target: test
    files:
      - bench/tb_psram_subsys.sv

// File: bench/tb_psram_subsys.sv
`timescale 1ns/100ps
`default_nettype none

module tb_psram_subsys import psram_pkg::*; ();

    localparam int timeout_cycles = 50;
    localparam int num_random = 200;

    logic        clk;
    logic        rst;
    logic        req;
    logic        we;
    psram_addr_t addr;
    burst_data_t wdata;
    logic        ack;
    burst_data_t rdata;

    // host view of the memory contents
    psram_word_t ref_mem [mem_depth];

    logic [15:0] lfsr;
    int          errors;
    int          checks;
    logic        stalled;

    psram_subsys dut_i (
        .clk  (clk),
        .rst  (rst),
        .req  (req),
        .we   (we),
        .addr (addr),
        .wdata(wdata),
        .ack  (ack),
        .rdata(rdata)
    );

    always #4 clk = ~clk;

    // fibonacci form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[62:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string msg, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t ns: %s, expected %h, got %h", $time, msg, expected, actual);
        end
    endtask

    // returns one ns after the edge where ack reached the level
    task automatic wait_ack(input logic level, input string phase);
        int cycles;
        cycles = 0;
        while (ack !== level && cycles < timeout_cycles) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (ack !== level) begin
            errors++;
            stalled = 1'b1;
            $display("Timeout: ack did not %s within %0d cycles", phase, timeout_cycles);
        end
    endtask

    task automatic run_burst(input logic wr, input psram_addr_t a, input burst_data_t d,
                             input int hold);
        burst_data_t expected;
        psram_addr_t wa;
        if (stalled) begin
            return;
        end
        for (int i = 0; i < burst_len; i++) begin
            // burst address wraps at the top of the array
            wa = a + psram_addr_t'(i);
            if (wr) begin
                ref_mem[wa] = d[i*psram_data_w +: psram_data_w];
            end
            expected[i*psram_data_w +: psram_data_w] = ref_mem[wa];
        end

        @(posedge clk);
        #1;
        req = 1'b1;
        we = wr;
        addr = a;
        wdata = d;
        wait_ack(1'b1, "rise after req");
        if (stalled) begin
            return;
        end

        if (!wr) begin
            for (int i = 0; i < burst_len; i++) begin
                wa = a + psram_addr_t'(i);
                check_value($sformatf("read word %0d at addr %0d", i, wa),
                            64'(expected[i*psram_data_w +: psram_data_w]),
                            64'(rdata[i*psram_data_w +: psram_data_w]));
            end
        end

        // host stalls the release phase
        for (int i = 0; i < hold; i++) begin
            @(posedge clk);
            #1;
            check_value("ack dropped while req held", 64'd1, 64'(ack));
            if (!wr) begin
                check_value("rdata changed while req held", expected, rdata);
            end
        end

        req = 1'b0;
        wait_ack(1'b0, "fall after req release");
    endtask

    initial begin
        logic [63:0] bits;
        logic        r_we;
        psram_addr_t r_addr;
        burst_data_t r_data;
        int          r_hold;

        clk = 1'b0;
        rst = 1'b1;
        req = 1'b0;
        we = 1'b0;
        addr = '0;
        wdata = '0;
        errors = 0;
        checks = 0;
        stalled = 1'b0;
        lfsr = 16'd65;
        for (int i = 0; i < mem_depth; i++) begin
            ref_mem[i] = '0;
        end

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // quiet port after reset
        repeat (3) begin
            @(posedge clk);
            #1;
            check_value("ack high before any req", 64'd0, 64'(ack));
        end

        // never written, so all zero
        run_burst(1'b0, 8'd128, '0, 0);
        run_burst(1'b0, 8'd200, '0, 1);

        // write then read back in order
        run_burst(1'b1, 8'h10, 64'h4444_3333_2222_1111, 0);
        run_burst(1'b0, 8'h10, '0, 2);

        // burst across the top of the array
        run_burst(1'b1, 8'd254, 64'hdddd_cccc_bbbb_aaaa, 0);
        run_burst(1'b0, 8'd0, '0, 0);
        run_burst(1'b0, 8'd254, '0, 0);

        for (int n = 0; n < num_random; n++) begin
            take_bits(1, bits);
            r_we = bits[0];
            take_bits(8, bits);
            r_addr = bits[7:0];
            take_bits(64, bits);
            r_data = bits;
            take_bits(3, bits);
            r_hold = int'(bits[2:0]);
            run_burst(r_we, r_addr, r_data, r_hold);
        end

        @(posedge clk);
        #1;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
src/psram_pkg.sv
src/count_reg.sv
src/psram_model.sv
src/psram_ctrl.sv
src/psram_subsys.sv
bench/tb_psram_subsys.sv

// File: src/count_reg.sv
`timescale 1ns/100ps
`default_nettype none

module count_reg #(
    parameter int width = 8
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              en,
    input  wire              load,
    input  wire [width-1:0]  count_load,
    output logic [width-1:0] count
);

    // load wins over count enable
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            count <= count_load;
        end else if (en) begin
            // wraps at the top of the range
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src/psram_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module psram_ctrl import psram_pkg::*; (
    input  wire              clk,
    input  wire              rst,
    input  wire              req,
    input  wire              we,
    input  wire psram_addr_t addr,
    input  wire burst_data_t wdata,
    output logic             ack,
    output burst_data_t      rdata,
    output logic             ce_n,
    output logic             adv_n,
    output logic             we_n,
    output logic             oe_n,
    output psram_addr_t      psram_addr,
    input  wire              mem_wait,
    inout  wire psram_word_t data
);

    ctrl_state_t state;

    logic                  we_q;
    psram_addr_t           addr_q;
    burst_data_t           wdata_q;
    logic [beat_idx_w-1:0] beat_idx;

    logic        burst_active;
    logic        xfer_phase;
    logic        beat_go;
    logic        last_beat;
    logic        drive_en;
    psram_word_t wr_word;

    assign burst_active = (state == ctrl_cmd) || (state == ctrl_wait) || (state == ctrl_beat);
    assign xfer_phase = (state == ctrl_wait) || (state == ctrl_beat);

    // first beat is taken in ctrl_wait as soon as mem_wait drops
    assign beat_go = (state == ctrl_beat) || (state == ctrl_wait && !mem_wait);
    assign last_beat = (beat_idx == beat_idx_w'(burst_len - 1));

    assign drive_en = we_q && beat_go;

    // chip strobes, all active low
    assign ce_n = !burst_active;
    assign adv_n = !(state == ctrl_cmd);
    assign we_n = !(we_q && burst_active);
    assign oe_n = !(!we_q && xfer_phase);
    assign psram_addr = addr_q;

    assign wr_word = wdata_q[beat_idx * psram_data_w +: psram_data_w];
    assign data = drive_en ? wr_word : 'z;

    // request fields held for the whole burst
    always_ff @(posedge clk) begin
        if (state == ctrl_idle && req) begin
            we_q <= we;
            addr_q <= addr;
            wdata_q <= wdata;
        end
    end

    // read beats assembled in order, word 0 lowest
    always_ff @(posedge clk) begin
        if (beat_go && !we_q) begin
            rdata[beat_idx * psram_data_w +: psram_data_w] <= data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ctrl_idle;
            ack <= 1'b0;
            beat_idx <= '0;
        end else begin
            case (state)
                ctrl_idle: begin
                    beat_idx <= '0;
                    if (req) begin
                        state <= ctrl_cmd;
                    end
                end
                ctrl_cmd: begin
                    state <= ctrl_wait;
                end
                ctrl_wait: begin
                    // no fixed latency assumed, follow the chip
                    if (!mem_wait) begin
                        beat_idx <= beat_idx + 1'b1;
                        state <= ctrl_beat;
                    end
                end
                ctrl_beat: begin
                    beat_idx <= beat_idx + 1'b1;
                    if (last_beat) begin
                        state <= ctrl_done;
                    end
                end
                ctrl_done: begin
                    ack <= 1'b1;
                    // host holding req keeps us parked here
                    if (ack && !req) begin
                        state <= ctrl_release;
                    end
                end
                ctrl_release: begin
                    ack <= 1'b0;
                    state <= ctrl_idle;
                end
                default: begin
                    state <= ctrl_idle;
                end
            endcase
        end
    end

    // four-phase rule on the host side
    a_ack_holds: assert property (
        @(posedge clk) disable iff (rst)
        $fell(ack) |-> !req
    );

    // no fight with the chip on the shared bus
    a_no_bus_clash: assert property (
        @(posedge clk) disable iff (rst)
        drive_en |-> (oe_n && data === wr_word)
    );

endmodule

`default_nettype wire

// File: src/psram_model.sv
`timescale 1ns/100ps
`default_nettype none

module psram_model import psram_pkg::*; (
    input  wire              clk,
    input  wire              rst,
    input  wire psram_addr_t psram_addr,
    input  wire              adv_n,
    input  wire              ce_n,
    input  wire              oe_n,
    input  wire              we_n,
    output logic             mem_wait,
    inout  wire psram_word_t data
);

    model_state_t state;
    model_state_t state_nxt;

    psram_word_t mem [mem_depth];

    psram_addr_t          addr_count;
    logic                 addr_load;
    logic                 addr_en;
    logic [lat_cnt_w-1:0] lat_count;
    logic                 lat_load;
    logic                 in_wait;
    logic                 in_data;
    logic                 lat_done;

    // array powers up cleared, reset leaves it alone
    initial begin
        for (int i = 0; i < mem_depth; i++) begin
            mem[i] = '0;
        end
    end

    // burst address, loaded while idle, walks through the data phase
    count_reg #(
        .width(psram_addr_w)
    ) addr_cnt_i (
        .clk       (clk),
        .rst       (rst),
        .en        (addr_en),
        .load      (addr_load),
        .count_load(psram_addr),
        .count     (addr_count)
    );

    // latency counter, free running once out of idle
    count_reg #(
        .width(lat_cnt_w)
    ) lat_cnt_i (
        .clk       (clk),
        .rst       (rst),
        .en        (1'b1),
        .load      (lat_load),
        .count_load('0),
        .count     (lat_count)
    );

    assign in_wait = (state == model_read_wait) || (state == model_write_wait);
    assign in_data = (state == model_read_data) || (state == model_write_data);

    assign addr_load = (state == model_idle);
    assign addr_en = in_data;
    assign lat_load = (state == model_idle);

    // data starts at the edge after the count reaches latency - 2
    assign lat_done = (lat_count == lat_cnt_w'(psram_latency - 2));

    assign mem_wait = in_wait && (lat_count <= lat_cnt_w'(psram_latency - 2));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= model_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            model_idle: begin
                if (!ce_n && !adv_n) begin
                    state_nxt = we_n ? model_read_wait : model_write_wait;
                end
            end
            model_read_wait: begin
                if (ce_n) begin
                    state_nxt = model_idle;
                end else if (lat_done) begin
                    state_nxt = model_read_data;
                end
            end
            model_write_wait: begin
                if (ce_n) begin
                    state_nxt = model_idle;
                end else if (lat_done) begin
                    state_nxt = model_write_data;
                end
            end
            model_read_data, model_write_data: begin
                // burst ends when the chip is deselected
                if (ce_n) begin
                    state_nxt = model_idle;
                end
            end
            default: begin
                state_nxt = model_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == model_write_data && !ce_n) begin
            mem[addr_count] <= data;
        end
    end

    // read word goes straight out, no output register
    assign data = (state == model_read_data && !oe_n && !ce_n) ? mem[addr_count] : 'z;

    // a new command only arrives between bursts
    a_adv_only_idle: assert property (
        @(posedge clk) disable iff (rst)
        (!adv_n && !ce_n) |-> (state == model_idle)
    );

endmodule

`default_nettype wire

// File: src/psram_pkg.sv
`default_nettype none

package psram_pkg;

    // chip geometry
    localparam int psram_addr_w = 8;
    localparam int psram_data_w = 16;
    localparam int mem_depth = 256;

    // burst timing
    localparam int psram_latency = 4;
    localparam int burst_len = 4;

    // counter widths derived from the timing above
    localparam int lat_cnt_w = $clog2(psram_latency);
    localparam int beat_idx_w = $clog2(burst_len);

    localparam int burst_data_w = psram_data_w * burst_len;

    typedef logic [psram_addr_w-1:0] psram_addr_t;
    typedef logic [psram_data_w-1:0] psram_word_t;

    // word 0 in the low bits
    typedef logic [burst_data_w-1:0] burst_data_t;

    typedef enum logic [2:0] {
        model_idle,
        model_read_wait,
        model_read_data,
        model_write_wait,
        model_write_data
    } model_state_t;

    // cmd holds ce_n and adv_n low for the latch edge
    typedef enum logic [2:0] {
        ctrl_idle,
        ctrl_cmd,
        ctrl_wait,
        ctrl_beat,
        ctrl_done,
        ctrl_release
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: src/psram_subsys.sv
`timescale 1ns/100ps
`default_nettype none

module psram_subsys import psram_pkg::*; (
    input  wire              clk,
    input  wire              rst,
    input  wire              req,
    input  wire              we,
    input  wire psram_addr_t addr,
    input  wire burst_data_t wdata,
    output wire              ack,
    output wire burst_data_t rdata
);

    // chip side strobes
    wire              ce_n;
    wire              adv_n;
    wire              we_n;
    wire              oe_n;
    wire psram_addr_t psram_addr;
    wire              mem_wait;

    // shared tristate data bus
    wire psram_word_t data_bus;

    psram_ctrl ctrl_i (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .we        (we),
        .addr      (addr),
        .wdata     (wdata),
        .ack       (ack),
        .rdata     (rdata),
        .ce_n      (ce_n),
        .adv_n     (adv_n),
        .we_n      (we_n),
        .oe_n      (oe_n),
        .psram_addr(psram_addr),
        .mem_wait  (mem_wait),
        .data      (data_bus)
    );

    psram_model mem_i (
        .clk       (clk),
        .rst       (rst),
        .psram_addr(psram_addr),
        .adv_n     (adv_n),
        .ce_n      (ce_n),
        .oe_n      (oe_n),
        .we_n      (we_n),
        .mem_wait  (mem_wait),
        .data      (data_bus)
    );

endmodule

`default_nettype wire
